/* Makefile */
# Verilator build and run for the back end testbench

VERILATOR ?= verilator
TOP       ?= tb_back_end
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+include
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/ex_mem.sv
rtl/mem_stage.sv
rtl/wb_select.sv
rtl/halt_fsm.sv
rtl/retire_counter.sv
rtl/back_end.sv
testbench/tb_back_end.sv

/* include/back_end_macros.svh */
`ifndef BACK_END_MACROS_SVH
`define BACK_END_MACROS_SVH

// ####################
// datapath widths
// ####################

`define WORD_W 16
`define REG_IDX_W 3

// ####################
// storage and counters
// ####################

`define DMEM_DEPTH 256 // words, not bytes
`define CNT_W 16

`endif

/* rtl/back_end.sv */
`timescale 1ns/10ps

module back_end (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               ex_valid,
   input  isa_pkg::word_t     ex_pc_inc,
   input  isa_pkg::word_t     ex_alu_out,
   input  isa_pkg::word_t     ex_store_data,
   input  isa_pkg::word_t     ex_lbi,
   input  isa_pkg::word_t     ex_slbi,
   input  logic               ex_alu_zero,
   input  logic               ex_alu_ltz,
   input  logic               ex_alu_lteq,
   input  logic               ex_alu_ofl,
   input  isa_pkg::set_sel_t  ex_set_sel,
   input  logic               ex_mem_en,
   input  logic               ex_mem_wr,
   input  logic               ex_wr_en,
   input  isa_pkg::reg_idx_t  ex_wr_reg,
   input  isa_pkg::wr_sel_t   ex_wr_sel,
   input  logic               ex_halt,
   output logic               rf_wr_en,
   output isa_pkg::reg_idx_t  rf_wr_idx,
   output isa_pkg::word_t     rf_wr_data,
   output ctrl_pkg::count_t   retired_count,
   output logic               halted,
   output logic               err
);

   logic accept;

   logic mem_valid, mem_alu_zero, mem_alu_ltz, mem_alu_lteq, mem_alu_ofl;
   logic mem_mem_en, mem_mem_wr, mem_wr_en, mem_halt;
   isa_pkg::word_t mem_pc_inc, mem_alu_out, mem_store_data, mem_lbi, mem_slbi;
   isa_pkg::set_sel_t mem_set_sel;
   isa_pkg::reg_idx_t mem_wr_reg;
   isa_pkg::wr_sel_t mem_wr_sel;

   logic wb_valid, wb_set_flag, wb_wr_en, wb_halt;
   isa_pkg::word_t wb_pc_inc, wb_alu_out, wb_lbi, wb_slbi, wb_mem_data;
   isa_pkg::reg_idx_t wb_wr_reg;
   isa_pkg::wr_sel_t wb_wr_sel;

   halt_fsm i_halt_fsm (
      .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_halt(ex_halt),
      .wb_valid(wb_valid), .wb_halt(wb_halt), .accept(accept), .halted(halted));

   ex_mem i_ex_mem (
      .clk(clk), .rst_n(rst_n), .accept(accept), .ex_valid(ex_valid),
      .ex_pc_inc(ex_pc_inc), .ex_alu_out(ex_alu_out), .ex_store_data(ex_store_data),
      .ex_lbi(ex_lbi), .ex_slbi(ex_slbi), .ex_alu_zero(ex_alu_zero),
      .ex_alu_ltz(ex_alu_ltz), .ex_alu_lteq(ex_alu_lteq), .ex_alu_ofl(ex_alu_ofl),
      .ex_set_sel(ex_set_sel), .ex_mem_en(ex_mem_en), .ex_mem_wr(ex_mem_wr),
      .ex_wr_en(ex_wr_en), .ex_wr_reg(ex_wr_reg), .ex_wr_sel(ex_wr_sel),
      .ex_halt(ex_halt), .mem_valid(mem_valid), .mem_pc_inc(mem_pc_inc),
      .mem_alu_out(mem_alu_out), .mem_store_data(mem_store_data), .mem_lbi(mem_lbi),
      .mem_slbi(mem_slbi), .mem_alu_zero(mem_alu_zero), .mem_alu_ltz(mem_alu_ltz),
      .mem_alu_lteq(mem_alu_lteq), .mem_alu_ofl(mem_alu_ofl), .mem_set_sel(mem_set_sel),
      .mem_mem_en(mem_mem_en), .mem_mem_wr(mem_mem_wr), .mem_wr_en(mem_wr_en),
      .mem_wr_reg(mem_wr_reg), .mem_wr_sel(mem_wr_sel), .mem_halt(mem_halt),
      .err(err));

   mem_stage i_mem_stage (
      .clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_pc_inc(mem_pc_inc),
      .mem_alu_out(mem_alu_out), .mem_store_data(mem_store_data), .mem_lbi(mem_lbi),
      .mem_slbi(mem_slbi), .mem_alu_zero(mem_alu_zero), .mem_alu_ltz(mem_alu_ltz),
      .mem_alu_lteq(mem_alu_lteq), .mem_alu_ofl(mem_alu_ofl), .mem_set_sel(mem_set_sel),
      .mem_mem_en(mem_mem_en), .mem_mem_wr(mem_mem_wr), .mem_wr_en(mem_wr_en),
      .mem_wr_reg(mem_wr_reg), .mem_wr_sel(mem_wr_sel), .mem_halt(mem_halt),
      .wb_valid(wb_valid), .wb_pc_inc(wb_pc_inc), .wb_alu_out(wb_alu_out),
      .wb_lbi(wb_lbi), .wb_slbi(wb_slbi), .wb_mem_data(wb_mem_data),
      .wb_set_flag(wb_set_flag), .wb_set_sel(), .wb_wr_en(wb_wr_en),
      .wb_wr_reg(wb_wr_reg), .wb_wr_sel(wb_wr_sel), .wb_halt(wb_halt));

   wb_select i_wb_select (
      .wb_valid(wb_valid), .wb_wr_en(wb_wr_en), .wb_wr_reg(wb_wr_reg),
      .wb_wr_sel(wb_wr_sel), .wb_pc_inc(wb_pc_inc), .wb_alu_out(wb_alu_out),
      .wb_mem_data(wb_mem_data), .wb_set_flag(wb_set_flag), .wb_lbi(wb_lbi),
      .wb_slbi(wb_slbi), .rf_wr_en(rf_wr_en), .rf_wr_idx(rf_wr_idx),
      .rf_wr_data(rf_wr_data));

   retire_counter i_retire_counter (
      .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .retired_count(retired_count));

endmodule

/* rtl/ctrl_pkg.sv */
`include "back_end_macros.svh"

package ctrl_pkg;

   typedef enum logic [1:0] {
      ST_RUN    = 2'd0,
      ST_DRAIN  = 2'd1, // halt accepted, waiting for it to retire
      ST_HALTED = 2'd2
   } halt_state_t;

   typedef logic [`CNT_W-1:0] count_t;

endpackage

/* rtl/ex_mem.sv */
`timescale 1ns/10ps

module ex_mem (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               accept,
   input  logic               ex_valid,
   input  isa_pkg::word_t     ex_pc_inc,
   input  isa_pkg::word_t     ex_alu_out,
   input  isa_pkg::word_t     ex_store_data,
   input  isa_pkg::word_t     ex_lbi,
   input  isa_pkg::word_t     ex_slbi,
   input  logic               ex_alu_zero,
   input  logic               ex_alu_ltz,
   input  logic               ex_alu_lteq,
   input  logic               ex_alu_ofl,
   input  isa_pkg::set_sel_t  ex_set_sel,
   input  logic               ex_mem_en,
   input  logic               ex_mem_wr,
   input  logic               ex_wr_en,
   input  isa_pkg::reg_idx_t  ex_wr_reg,
   input  isa_pkg::wr_sel_t   ex_wr_sel,
   input  logic               ex_halt,
   output logic               mem_valid,
   output isa_pkg::word_t     mem_pc_inc,
   output isa_pkg::word_t     mem_alu_out,
   output isa_pkg::word_t     mem_store_data,
   output isa_pkg::word_t     mem_lbi,
   output isa_pkg::word_t     mem_slbi,
   output logic               mem_alu_zero,
   output logic               mem_alu_ltz,
   output logic               mem_alu_lteq,
   output logic               mem_alu_ofl,
   output isa_pkg::set_sel_t  mem_set_sel,
   output logic               mem_mem_en,
   output logic               mem_mem_wr,
   output logic               mem_wr_en,
   output isa_pkg::reg_idx_t  mem_wr_reg,
   output isa_pkg::wr_sel_t   mem_wr_sel,
   output logic               mem_halt,
   output logic               err
);

   logic take;

   assign take = ex_valid & accept; // a stall or a drop loads a bubble

   // flag unknown execute outputs only while they are meant to be valid
   assign err = (ex_valid === 1'b1) &&
                ((^{ex_pc_inc, ex_alu_out, ex_store_data, ex_lbi, ex_slbi,
                    ex_alu_zero, ex_alu_ltz, ex_alu_lteq, ex_alu_ofl, ex_set_sel,
                    ex_mem_en, ex_mem_wr, ex_wr_en, ex_wr_reg, ex_wr_sel,
                    ex_halt}) === 1'bx);

   // ####################
   // pipeline register
   // ####################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_valid      <= 1'b0;
         mem_mem_en     <= 1'b0;
         mem_mem_wr     <= 1'b0;
         mem_wr_en      <= 1'b0;
         mem_halt       <= 1'b0;
         mem_pc_inc     <= '0;
         mem_alu_out    <= '0;
         mem_store_data <= '0;
         mem_lbi        <= '0;
         mem_slbi       <= '0;
         mem_alu_zero   <= 1'b0;
         mem_alu_ltz    <= 1'b0;
         mem_alu_lteq   <= 1'b0;
         mem_alu_ofl    <= 1'b0;
         mem_set_sel    <= isa_pkg::SET_EQ;
         mem_wr_reg     <= '0;
         mem_wr_sel     <= isa_pkg::WB_ALU;
      end else begin
         mem_valid      <= take;
         mem_mem_en     <= take & ex_mem_en;
         mem_mem_wr     <= take & ex_mem_wr;
         mem_wr_en      <= take & ex_wr_en;
         mem_halt       <= take & ex_halt;
         mem_pc_inc     <= ex_pc_inc; // payload is harmless under a bubble
         mem_alu_out    <= ex_alu_out;
         mem_store_data <= ex_store_data;
         mem_lbi        <= ex_lbi;
         mem_slbi       <= ex_slbi;
         mem_alu_zero   <= ex_alu_zero;
         mem_alu_ltz    <= ex_alu_ltz;
         mem_alu_lteq   <= ex_alu_lteq;
         mem_alu_ofl    <= ex_alu_ofl;
         mem_set_sel    <= ex_set_sel;
         mem_wr_reg     <= ex_wr_reg;
         mem_wr_sel     <= ex_wr_sel;
      end
   end

   // execute must never hand over a store that is not also a memory access
   a_wr_needs_en : assert property (@(posedge clk) disable iff (!rst_n)
      mem_mem_wr |-> mem_mem_en);

endmodule

/* rtl/halt_fsm.sv */
`timescale 1ns/10ps

module halt_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic ex_valid,
   input  logic ex_halt,
   input  logic wb_valid,
   input  logic wb_halt,
   output logic accept,
   output logic halted
);

   ctrl_pkg::halt_state_t state;
   ctrl_pkg::halt_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         ctrl_pkg::ST_RUN: begin
            if (ex_valid && ex_halt) state_nxt = ctrl_pkg::ST_DRAIN;
         end
         ctrl_pkg::ST_DRAIN: begin
            if (wb_valid && wb_halt) state_nxt = ctrl_pkg::ST_HALTED;
         end
         ctrl_pkg::ST_HALTED: begin
            state_nxt = ctrl_pkg::ST_HALTED; // only reset gets out of here
         end
         default: begin
            state_nxt = ctrl_pkg::ST_RUN;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) state <= ctrl_pkg::ST_RUN;
      else        state <= state_nxt;
   end

   assign accept = (state == ctrl_pkg::ST_RUN); // the halt itself is still taken
   assign halted = (state == ctrl_pkg::ST_HALTED);

   a_halted_sticky : assert property (@(posedge clk) disable iff (!rst_n)
      (state == ctrl_pkg::ST_HALTED) |=> (state == ctrl_pkg::ST_HALTED));

endmodule

/* rtl/isa_pkg.sv */
`include "back_end_macros.svh"

package isa_pkg;

   typedef logic [`WORD_W-1:0] word_t;

   typedef logic [`REG_IDX_W-1:0] reg_idx_t;

   // source of the register file write data
   typedef enum logic [2:0] {
      WB_ALU    = 3'd0,
      WB_MEM    = 3'd1,
      WB_PC_INC = 3'd2, // link value for jal and jalr
      WB_SET    = 3'd3,
      WB_LBI    = 3'd4,
      WB_SLBI   = 3'd5
   } wr_sel_t;

   // condition tested by seq, slt, sle and sco
   typedef enum logic [1:0] {
      SET_EQ = 2'd0, // alu zero flag
      SET_LT = 2'd1, // alu less than zero flag
      SET_LE = 2'd2, // alu less or equal flag
      SET_CO = 2'd3  // alu carry out flag
   } set_sel_t;

endpackage

/* rtl/mem_stage.sv */
`timescale 1ns/10ps

`include "back_end_macros.svh"

module mem_stage #(
   parameter int DEPTH = `DMEM_DEPTH
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               mem_valid,
   input  isa_pkg::word_t     mem_pc_inc,
   input  isa_pkg::word_t     mem_alu_out,
   input  isa_pkg::word_t     mem_store_data,
   input  isa_pkg::word_t     mem_lbi,
   input  isa_pkg::word_t     mem_slbi,
   input  logic               mem_alu_zero,
   input  logic               mem_alu_ltz,
   input  logic               mem_alu_lteq,
   input  logic               mem_alu_ofl,
   input  isa_pkg::set_sel_t  mem_set_sel,
   input  logic               mem_mem_en,
   input  logic               mem_mem_wr,
   input  logic               mem_wr_en,
   input  isa_pkg::reg_idx_t  mem_wr_reg,
   input  isa_pkg::wr_sel_t   mem_wr_sel,
   input  logic               mem_halt,
   output logic               wb_valid,
   output isa_pkg::word_t     wb_pc_inc,
   output isa_pkg::word_t     wb_alu_out,
   output isa_pkg::word_t     wb_lbi,
   output isa_pkg::word_t     wb_slbi,
   output isa_pkg::word_t     wb_mem_data,
   output logic               wb_set_flag,
   output isa_pkg::set_sel_t  wb_set_sel,
   output logic               wb_wr_en,
   output isa_pkg::reg_idx_t  wb_wr_reg,
   output isa_pkg::wr_sel_t   wb_wr_sel,
   output logic               wb_halt
);

   isa_pkg::word_t dmem [DEPTH];
   logic [$clog2(DEPTH)-1:0] addr;
   logic store;
   logic load;
   logic set_flag;

   assign addr  = mem_alu_out[$clog2(DEPTH)-1:0]; // word address, upper bits ignored
   assign store = mem_valid & mem_mem_en & mem_mem_wr;
   assign load  = mem_valid & mem_mem_en & ~mem_mem_wr;

   always_comb begin
      case (mem_set_sel)
         isa_pkg::SET_EQ: set_flag = mem_alu_zero;
         isa_pkg::SET_LT: set_flag = mem_alu_ltz;
         isa_pkg::SET_LE: set_flag = mem_alu_lteq;
         default:         set_flag = mem_alu_ofl;
      endcase
   end

   // ####################
   // data memory
   // ####################

   always_ff @(posedge clk) begin
      if (store) begin
         dmem[addr] <= mem_store_data;
      end
      if (load) begin
         wb_mem_data <= dmem[addr]; // a store one cycle earlier is already visible
      end
   end

   // ####################
   // write-back register
   // ####################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         wb_wr_en <= 1'b0;
         wb_halt  <= 1'b0;
      end else begin
         wb_valid <= mem_valid;
         wb_wr_en <= mem_wr_en;
         wb_halt  <= mem_halt;
      end
   end

   always_ff @(posedge clk) begin
      wb_pc_inc   <= mem_pc_inc;
      wb_alu_out  <= mem_alu_out;
      wb_lbi      <= mem_lbi;
      wb_slbi     <= mem_slbi;
      wb_set_flag <= set_flag;
      wb_set_sel  <= mem_set_sel;
      wb_wr_reg   <= mem_wr_reg;
      wb_wr_sel   <= mem_wr_sel;
   end

   // bubbles from the pipeline register carry no store
   a_store_valid : assert property (@(posedge clk) disable iff (!rst_n)
      (mem_mem_en && mem_mem_wr) |-> mem_valid);

endmodule

/* rtl/retire_counter.sv */
`timescale 1ns/10ps

`include "back_end_macros.svh"

module retire_counter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_valid,
   output ctrl_pkg::count_t  retired_count
);

   logic at_max;

   assign at_max = (retired_count == {`CNT_W{1'b1}});

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         retired_count <= '0;
      end else if (wb_valid && !at_max) begin
         retired_count <= retired_count + 1'b1; // holds at the top instead of wrapping
      end
   end

endmodule

/* rtl/wb_select.sv */
`timescale 1ns/10ps

module wb_select (
   input  logic               wb_valid,
   input  logic               wb_wr_en,
   input  isa_pkg::reg_idx_t  wb_wr_reg,
   input  isa_pkg::wr_sel_t   wb_wr_sel,
   input  isa_pkg::word_t     wb_pc_inc,
   input  isa_pkg::word_t     wb_alu_out,
   input  isa_pkg::word_t     wb_mem_data,
   input  logic               wb_set_flag,
   input  isa_pkg::word_t     wb_lbi,
   input  isa_pkg::word_t     wb_slbi,
   output logic               rf_wr_en,
   output isa_pkg::reg_idx_t  rf_wr_idx,
   output isa_pkg::word_t     rf_wr_data
);

   isa_pkg::word_t set_word;

   assign set_word = isa_pkg::word_t'(wb_set_flag); // zero extended, value 0 or 1

   assign rf_wr_en  = wb_valid & wb_wr_en;
   assign rf_wr_idx = wb_wr_reg;

   always_comb begin
      case (wb_wr_sel)
         isa_pkg::WB_ALU: begin
            rf_wr_data = wb_alu_out;
         end
         isa_pkg::WB_MEM: begin
            rf_wr_data = wb_mem_data;
         end
         isa_pkg::WB_PC_INC: begin
            rf_wr_data = wb_pc_inc;
         end
         isa_pkg::WB_SET: begin
            rf_wr_data = set_word;
         end
         isa_pkg::WB_LBI: begin
            rf_wr_data = wb_lbi;
         end
         isa_pkg::WB_SLBI: begin
            rf_wr_data = wb_slbi;
         end
         default: begin
            rf_wr_data = wb_alu_out; // unused codes fall back to the alu
         end
      endcase
   end

endmodule

/* testbench/tb_back_end.sv */
`timescale 1ns/10ps

`include "back_end_macros.svh"

module tb_back_end;

   localparam int ADDR_W = $clog2(`DMEM_DEPTH);

   logic clk;
   logic rst_n;
   logic ex_valid, ex_alu_zero, ex_alu_ltz, ex_alu_lteq, ex_alu_ofl;
   logic ex_mem_en, ex_mem_wr, ex_wr_en, ex_halt;
   isa_pkg::word_t ex_pc_inc, ex_alu_out, ex_store_data, ex_lbi, ex_slbi;
   isa_pkg::set_sel_t ex_set_sel;
   isa_pkg::reg_idx_t ex_wr_reg;
   isa_pkg::wr_sel_t ex_wr_sel;
   logic rf_wr_en, halted, err;
   isa_pkg::reg_idx_t rf_wr_idx;
   isa_pkg::word_t rf_wr_data;
   ctrl_pkg::count_t retired_count;

   // next instruction to be driven
   logic ins_valid, ins_mem_en, ins_mem_wr, ins_wr_en, ins_halt;
   logic [3:0] ins_flags; // ofl, lteq, ltz, zero
   isa_pkg::word_t ins_pc_inc, ins_alu_out, ins_store_data, ins_lbi, ins_slbi;
   isa_pkg::set_sel_t ins_set_sel;
   isa_pkg::reg_idx_t ins_wr_reg;
   isa_pkg::wr_sel_t ins_wr_sel;

   isa_pkg::word_t model_mem [`DMEM_DEPTH];
   isa_pkg::reg_idx_t exp_idx [$];
   isa_pkg::word_t exp_data [$];
   int exp_cyc [$];
   isa_pkg::word_t stored_addr [$];
   isa_pkg::reg_idx_t cmp_idx;
   isa_pkg::word_t cmp_data;
   int cmp_cyc;

   int seed = 65940;
   int cyc = 0;
   int errors = 0;
   int errors_at_start = 0;
   int n_tests = 0;
   int n_writes = 0;
   int n_accepted = 0;
   logic halt_seen = 1'b0;
   int i;
   int t;
   logic [31:0] r;

   isa_pkg::wr_sel_t plain_sel [4] = '{isa_pkg::WB_ALU, isa_pkg::WB_PC_INC,
                                       isa_pkg::WB_LBI, isa_pkg::WB_SLBI};

   back_end i_back_end (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // ####################
   // reference model
   // ####################

   function automatic isa_pkg::word_t expected_data(
      input isa_pkg::wr_sel_t sel,
      input isa_pkg::set_sel_t cond,
      input logic [3:0] flags,
      input isa_pkg::word_t pc_inc, alu_out, lbi, slbi, mem_word);
      logic flag;
      case (cond)
         isa_pkg::SET_EQ: flag = flags[0];
         isa_pkg::SET_LT: flag = flags[1];
         isa_pkg::SET_LE: flag = flags[2];
         default:         flag = flags[3];
      endcase
      case (sel)
         isa_pkg::WB_MEM:    expected_data = mem_word;
         isa_pkg::WB_PC_INC: expected_data = pc_inc;
         isa_pkg::WB_SET:    expected_data = flag ? 16'd1 : 16'd0;
         isa_pkg::WB_LBI:    expected_data = lbi;
         isa_pkg::WB_SLBI:   expected_data = slbi;
         default:            expected_data = alu_out;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got, exp);
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
   endtask

   task automatic random_ins(input isa_pkg::wr_sel_t sel);
      logic [31:0] v;
      v = $random(seed);
      ins_pc_inc = v[15:0];
      ins_alu_out = v[31:16];
      v = $random(seed);
      ins_store_data = v[15:0];
      ins_lbi = v[31:16];
      v = $random(seed);
      ins_slbi = v[15:0];
      ins_flags = v[19:16];
      ins_set_sel = isa_pkg::set_sel_t'(v[21:20]);
      ins_wr_reg = v[24:22];
      ins_wr_sel = sel;
      ins_valid = 1'b1;
      ins_wr_en = 1'b1;
      ins_mem_en = 1'b0;
      ins_mem_wr = 1'b0;
      ins_halt = 1'b0;
   endtask

   // drives one strobe and records what write-back must show for it
   task automatic issue();
      isa_pkg::word_t exp;
      @(posedge clk);
      ex_valid <= ins_valid;
      ex_pc_inc <= ins_pc_inc;
      ex_alu_out <= ins_alu_out;
      ex_store_data <= ins_store_data;
      ex_lbi <= ins_lbi;
      ex_slbi <= ins_slbi;
      ex_alu_zero <= ins_flags[0];
      ex_alu_ltz <= ins_flags[1];
      ex_alu_lteq <= ins_flags[2];
      ex_alu_ofl <= ins_flags[3];
      ex_set_sel <= ins_set_sel;
      ex_mem_en <= ins_mem_en;
      ex_mem_wr <= ins_mem_wr;
      ex_wr_en <= ins_wr_en;
      ex_wr_reg <= ins_wr_reg;
      ex_wr_sel <= ins_wr_sel;
      ex_halt <= ins_halt;
      if (ins_valid && !halt_seen) begin
         n_accepted++;
         if (ins_wr_en) begin
            exp = expected_data(ins_wr_sel, ins_set_sel, ins_flags, ins_pc_inc, ins_alu_out,
                                ins_lbi, ins_slbi, model_mem[ins_alu_out[ADDR_W-1:0]]);
            exp_idx.push_back(ins_wr_reg);
            exp_data.push_back(exp);
            exp_cyc.push_back(cyc + 3); // captured on the next edge, then two stages
         end
         if (ins_mem_en && ins_mem_wr) model_mem[ins_alu_out[ADDR_W-1:0]] = ins_store_data;
         if (ins_halt) halt_seen = 1'b1;
      end
   endtask

   task automatic wait_drain();
      @(posedge clk);
      ex_valid <= 1'b0;
      t = 0;
      while (exp_data.size() != 0 && t < 20) begin
         @(negedge clk);
         t++;
      end
      if (exp_data.size() != 0) begin
         $display("timeout: %0d expected register writes never appeared", exp_data.size());
         errors++;
         exp_idx.delete();
         exp_data.delete();
         exp_cyc.delete();
      end
      repeat (3) @(negedge clk); // instructions without a write still have to retire
      if (retired_count !== n_accepted[15:0])
         report_mismatch("retired_count", 32'(retired_count), 32'(n_accepted[15:0]));
   endtask

   task automatic end_test(input string name);
      $display("test %-10s %0d errors", name, errors - errors_at_start);
      errors_at_start = errors;
      n_tests++;
   endtask

   // ####################
   // compare
   // ####################

   always @(negedge clk) begin
      if (rst_n) begin
         if (err !== 1'b0) report_mismatch("err", 32'(err), 32'd0);
         if (rf_wr_en === 1'b1) begin
            n_writes++;
            if (exp_data.size() == 0) begin
               report_mismatch("rf_wr_en", 32'(rf_wr_en), 32'd0);
            end else begin
               cmp_idx = exp_idx.pop_front();
               cmp_data = exp_data.pop_front();
               cmp_cyc = exp_cyc.pop_front();
               if (cyc != cmp_cyc) report_mismatch("write cycle", cyc, cmp_cyc);
               if (rf_wr_idx !== cmp_idx) report_mismatch("rf_wr_idx", 32'(rf_wr_idx), 32'(cmp_idx));
               if (rf_wr_data !== cmp_data)
                  report_mismatch("rf_wr_data", 32'(rf_wr_data), 32'(cmp_data));
            end
         end
      end
   end

   // ####################
   // stimulus
   // ####################

   initial begin
      rst_n = 1'b0;
      ex_valid = 1'b0;
      {ex_pc_inc, ex_alu_out, ex_store_data, ex_lbi, ex_slbi} = '0;
      {ex_alu_zero, ex_alu_ltz, ex_alu_lteq, ex_alu_ofl} = '0;
      {ex_mem_en, ex_mem_wr, ex_wr_en, ex_halt} = '0;
      ex_set_sel = isa_pkg::SET_EQ;
      ex_wr_reg = '0;
      ex_wr_sel = isa_pkg::WB_ALU;
      repeat (5) @(posedge clk);
      @(negedge clk);
      if (rf_wr_en !== 1'b0) report_mismatch("rf_wr_en", 32'(rf_wr_en), 32'd0);
      if (halted !== 1'b0) report_mismatch("halted", 32'(halted), 32'd0);
      if (err !== 1'b0) report_mismatch("err", 32'(err), 32'd0);
      if (retired_count !== '0) report_mismatch("retired_count", 32'(retired_count), 32'd0);
      @(posedge clk);
      rst_n <= 1'b1;
      end_test("reset");

      for (i = 0; i < 24; i++) begin
         random_ins(plain_sel[i % 4]);
         issue();
      end
      wait_drain();
      end_test("wb_select");

      for (i = 0; i < 16; i++) begin
         random_ins(isa_pkg::WB_SET);
         ins_set_sel = isa_pkg::set_sel_t'(i[1:0]);
         issue();
      end
      wait_drain();
      end_test("set");

      for (i = 0; i < 12; i++) begin
         random_ins(isa_pkg::WB_ALU);
         ins_wr_en = 1'b0;
         ins_mem_en = 1'b1;
         ins_mem_wr = 1'b1;
         issue();
         stored_addr.push_back(ins_alu_out);
         random_ins(isa_pkg::WB_MEM);
         ins_mem_en = 1'b1;
         r = $random(seed);
         if (i % 2 == 0) ins_alu_out = stored_addr[$]; // back to back with its store
         else ins_alu_out = stored_addr[r % stored_addr.size()];
         issue();
      end
      wait_drain();
      end_test("memory");

      for (i = 0; i < 20; i++) begin
         random_ins(isa_pkg::WB_ALU);
         r = $random(seed);
         ins_valid = r[0];
         ins_wr_en = r[1];
         issue();
      end
      wait_drain();
      end_test("bubbles");

      for (i = 0; i < 11; i++) begin
         random_ins(isa_pkg::WB_ALU);
         if (i == 4) begin
            ins_halt = 1'b1;
            ins_wr_en = 1'b0;
         end
         issue();
      end
      wait_drain();
      t = 0;
      while (halted !== 1'b1 && t < 20) begin
         @(negedge clk);
         t++;
      end
      if (halted !== 1'b1) begin
         $display("timeout: halted never rose after the halt instruction");
         errors++;
      end
      repeat (8) begin
         @(negedge clk);
         if (halted !== 1'b1) report_mismatch("halted", 32'(halted), 32'd1);
      end
      if (retired_count !== n_accepted[15:0])
         report_mismatch("retired_count", 32'(retired_count), 32'(n_accepted[15:0]));
      end_test("halt");

      $display("%0d tests, %0d writes compared, %0d errors", n_tests, n_writes, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
